// File: include/pcie_consts.svh
`ifndef PCIE_CONSTS_SVH
`define PCIE_CONSTS_SVH

// queue pages and tail table entries
`define MAX_QUEUES 4

// queue index, log2 of MAX_QUEUES
`define QUEUE_IDX_WIDTH 2

// ring buffer pointer
`define TAIL_WIDTH 16

// pio address space
`define PIO_ADDR_WIDTH 16

// first bit of the page index in a pio address
`define PAGE_LSB 12

// one register page, four dwords
`define PIO_DATA_WIDTH 128

// status bus address
`define STATUS_ADDR_WIDTH 8

`endif

// File: logic/pcie_pkg.sv
`default_nettype none

`include "pcie_consts.svh"

package pcie_pkg;

    typedef struct packed {
        logic [`PIO_ADDR_WIDTH-1:0]   address;
        logic                         read;
        logic                         write;
        logic [`PIO_DATA_WIDTH-1:0]   writedata;
        logic [`PIO_DATA_WIDTH/8-1:0] byteenable;
    } pio_req_t;

    // dwords 1 to 3 of a page
    typedef struct packed {
        logic [31:0] head;
        logic [63:0] kmem_addr;
    } queue_cfg_t;

    typedef queue_cfg_t [`MAX_QUEUES-1:0] queue_cfg_array_t;

    typedef logic [`MAX_QUEUES-1:0][`TAIL_WIDTH-1:0] tail_array_t;

    typedef struct packed {
        logic [`QUEUE_IDX_WIDTH-1:0] queue_id;
        logic [`TAIL_WIDTH-1:0]      tail;
        logic [31:0]                 head;
        logic [63:0]                 kmem_addr;
    } active_queue_t;

    // bit 0 is the disable flag
    typedef struct packed {
        logic [32-`QUEUE_IDX_WIDTH-3:0] reserved;
        logic [`QUEUE_IDX_WIDTH:0]      num_queues;
        logic                           disable_pcie;
    } ctrl_reg_t;

    typedef struct packed {
        logic [`STATUS_ADDR_WIDTH-1:0] address;
        logic                          read;
        logic                          write;
        logic [31:0]                   writedata;
    } status_req_t;

    typedef struct packed {
        logic [`QUEUE_IDX_WIDTH-1:0] queue_id;
        logic [`TAIL_WIDTH-1:0]      tail;
    } tbl_wr_req_t;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_BRAM_DELAY,
        SCHED_SWITCH_QUEUE
    } sched_state_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TABLE_WAIT,
        ST_TABLE_RSP
    } status_state_t;

endpackage

`default_nettype wire

// File: logic/pio_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module pio_reg_file
    import pcie_pkg::*;
(
    input  wire logic                        pcie_clk,
    input  wire logic                        pcie_reset_n,
    input  wire pio_req_t                    pio_req,
    input  wire tail_array_t                 tails,
    output logic [`PIO_DATA_WIDTH-1:0]       pio_readdata,
    output logic                             pio_readdatavalid,
    output queue_cfg_array_t                 queue_cfgs
);

    logic [`QUEUE_IDX_WIDTH-1:0] page_idx;
    logic [`QUEUE_IDX_WIDTH-1:0] rd_idx_r;
    logic                        rd_valid_r;
    queue_cfg_array_t            cfg_r;

    // page index sits right above the 4 KB page offset
    assign page_idx   = pio_req.address[`PAGE_LSB +: `QUEUE_IDX_WIDTH];
    assign queue_cfgs = cfg_r;

    // a dword is only updated when all four of its byte enables are set;
    // dword 0 holds the tail and belongs to the scheduler
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            cfg_r <= '0;
        end else if (pio_req.write) begin
            if (&pio_req.byteenable[4 +: 4]) begin
                cfg_r[page_idx].head <= pio_req.writedata[32 +: 32];
            end
            if (&pio_req.byteenable[8 +: 4]) begin
                cfg_r[page_idx].kmem_addr[31:0] <= pio_req.writedata[64 +: 32];
            end
            if (&pio_req.byteenable[12 +: 4]) begin
                cfg_r[page_idx].kmem_addr[63:32] <= pio_req.writedata[96 +: 32];
            end
        end
    end

    // read valid pipeline, two stages
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_valid_r        <= 1'b0;
            pio_readdatavalid <= 1'b0;
        end else begin
            rd_valid_r        <= pio_req.read;
            pio_readdatavalid <= rd_valid_r;
        end
    end

    // page data follows the valid pipeline
    always_ff @(posedge pcie_clk) begin
        rd_idx_r     <= page_idx;
        pio_readdata <= {
            cfg_r[rd_idx_r].kmem_addr[63:32],
            cfg_r[rd_idx_r].kmem_addr[31:0],
            cfg_r[rd_idx_r].head,
            {(32-`TAIL_WIDTH){1'b0}}, tails[rd_idx_r]
        };
    end

    // the port carries one command per cycle
    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !(pio_req.read && pio_req.write))
        else $error("pio read and write in the same cycle");

endmodule

`default_nettype wire

// File: logic/queue_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module queue_scheduler
    import pcie_pkg::*;
(
    input  wire logic                         pcie_clk,
    input  wire logic                         pcie_reset_n,
    input  wire logic                         dma_done_valid,
    input  wire logic [`TAIL_WIDTH-1:0]       dma_done_tail,
    output logic                              dma_done_ready,
    input  wire logic [`QUEUE_IDX_WIDTH:0]    num_queues,
    input  wire queue_cfg_array_t             queue_cfgs,
    output tail_array_t                       tails,
    output active_queue_t                     active_queue,
    output logic                              tbl_wr_valid,
    output tbl_wr_req_t                       tbl_wr_req,
    input  wire logic                         tbl_wr_ready
);

    sched_state_t                state;
    logic [`QUEUE_IDX_WIDTH-1:0] cur_id;
    logic [`QUEUE_IDX_WIDTH-1:0] next_id;
    logic [`QUEUE_IDX_WIDTH-1:0] id_d;
    logic                        wr_grant;
    tail_array_t                 tails_r;

    assign dma_done_ready = (state == SCHED_IDLE);
    assign tbl_wr_valid   = (state == SCHED_SWITCH_QUEUE);
    assign wr_grant       = tbl_wr_valid && tbl_wr_ready;
    assign tails          = tails_r;

    always_comb begin
        tbl_wr_req.queue_id = cur_id;
        tbl_wr_req.tail     = tails_r[cur_id];
    end

    // round robin over the enabled queues, 0 or 1 pins queue 0
    always_comb begin
        if (num_queues <= 1) begin
            next_id = '0;
        end else if ({1'b0, cur_id} == num_queues - 1'b1) begin
            next_id = '0;
        end else begin
            next_id = cur_id + 1'b1;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state   <= SCHED_IDLE;
            cur_id  <= '0;
            tails_r <= '0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (dma_done_valid) begin
                        tails_r[cur_id] <= dma_done_tail;
                        state           <= SCHED_BRAM_DELAY;
                    end
                end
                // one cycle for the table port to settle
                SCHED_BRAM_DELAY: state <= SCHED_SWITCH_QUEUE;
                SCHED_SWITCH_QUEUE: begin
                    if (tbl_wr_ready) begin
                        cur_id <= next_id;
                        state  <= SCHED_IDLE;
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    // look ahead to the new id so the outputs are current when ready rises
    assign id_d = wr_grant ? next_id : cur_id;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            active_queue <= '0;
        end else begin
            active_queue.queue_id  <= id_d;
            active_queue.tail      <= tails_r[id_d];
            active_queue.head      <= queue_cfgs[id_d].head;
            active_queue.kmem_addr <= queue_cfgs[id_d].kmem_addr;
        end
    end

    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        tbl_wr_valid && !tbl_wr_ready |=> tbl_wr_valid && $stable(tbl_wr_req))
        else $error("tail table write request changed before grant");

endmodule

`default_nettype wire

// File: logic/queue_tail_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module queue_tail_table
    import pcie_pkg::*;
(
    input  wire logic                          pcie_clk,
    input  wire logic                          pcie_reset_n,
    input  wire logic                          tbl_wr_valid,
    input  wire tbl_wr_req_t                   tbl_wr_req,
    output logic                               tbl_wr_ready,
    input  wire logic                          tbl_rd_valid,
    input  wire logic [`QUEUE_IDX_WIDTH-1:0]   tbl_rd_queue,
    output logic                               tbl_rd_ready,
    output logic [`TAIL_WIDTH-1:0]             tbl_rd_data,
    output logic                               tbl_rd_rsp_valid
);

    tail_array_t mem;
    logic        wr_grant;
    logic        rd_grant;

    // fixed priority, the scheduler write always owns the port
    assign tbl_wr_ready = 1'b1;
    assign tbl_rd_ready = !tbl_wr_valid;

    assign wr_grant = tbl_wr_valid && tbl_wr_ready;
    assign rd_grant = tbl_rd_valid && tbl_rd_ready;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            mem <= '0;
        end else if (wr_grant) begin
            mem[tbl_wr_req.queue_id] <= tbl_wr_req.tail;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            tbl_rd_rsp_valid <= 1'b0;
        end else begin
            tbl_rd_rsp_valid <= rd_grant;
        end
    end

    // registered read data, one cycle after the grant
    always_ff @(posedge pcie_clk) begin
        if (rd_grant) begin
            tbl_rd_data <= mem[tbl_rd_queue];
        end
    end

    // single port, only one access per cycle
    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !(wr_grant && rd_grant))
        else $error("tail table granted read and write together");

endmodule

`default_nettype wire

// File: logic/status_bus_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module status_bus_slave
    import pcie_pkg::*;
(
    input  wire logic                          pcie_clk,
    input  wire logic                          pcie_reset_n,
    input  wire status_req_t                   status_req,
    output logic [31:0]                        status_readdata,
    output logic                               status_readdata_valid,
    output logic [`QUEUE_IDX_WIDTH:0]          num_queues,
    output logic                               disable_pcie,
    output logic                               tbl_rd_valid,
    output logic [`QUEUE_IDX_WIDTH-1:0]        tbl_rd_queue,
    input  wire logic                          tbl_rd_ready,
    input  wire logic [`TAIL_WIDTH-1:0]        tbl_rd_data,
    input  wire logic                          tbl_rd_rsp_valid
);

    status_req_t                   req_r;
    status_state_t                 state;
    ctrl_reg_t                     ctrl;
    logic [`QUEUE_IDX_WIDTH-1:0]   rd_queue_r;
    logic [`STATUS_ADDR_WIDTH-1:0] entry_addr;
    logic                          ctrl_sel;
    logic                          rd_pending;

    // address 0 is control, 1 + q is tail entry q
    assign ctrl_sel   = (req_r.address == '0);
    assign entry_addr = req_r.address - 1'b1;

    assign tbl_rd_valid = (state == ST_TABLE_WAIT);
    assign tbl_rd_queue = rd_queue_r;
    assign disable_pcie = ctrl.disable_pcie;
    assign num_queues   = ctrl.num_queues;
    assign rd_pending   = req_r.read || (state != ST_IDLE);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            req_r                 <= '0;
            ctrl                  <= '0;
            state                 <= ST_IDLE;
            status_readdata_valid <= 1'b0;
        end else begin
            req_r                 <= status_req;
            status_readdata_valid <= 1'b0;
            // table entries are read only
            if (req_r.write && ctrl_sel) begin
                ctrl <= req_r.writedata;
            end
            if (req_r.read && ctrl_sel) begin
                status_readdata_valid <= 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (req_r.read && !ctrl_sel) begin
                        state <= ST_TABLE_WAIT;
                    end
                end
                // may stall behind a scheduler write
                ST_TABLE_WAIT: begin
                    if (tbl_rd_ready) begin
                        state <= ST_TABLE_RSP;
                    end
                end
                ST_TABLE_RSP: begin
                    if (tbl_rd_rsp_valid) begin
                        status_readdata_valid <= 1'b1;
                        state                 <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (state == ST_IDLE && req_r.read) begin
            rd_queue_r <= entry_addr[`QUEUE_IDX_WIDTH-1:0];
        end
        if (req_r.read && ctrl_sel) begin
            status_readdata <= ctrl;
        end else if (state == ST_TABLE_RSP && tbl_rd_rsp_valid) begin
            status_readdata <= {{(32-`TAIL_WIDTH){1'b0}}, tbl_rd_data};
        end
    end

    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        status_req.read |-> !rd_pending)
        else $error("status read issued while another is outstanding");

endmodule

`default_nettype wire

// File: logic/pcie_queue_mgr.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module pcie_queue_mgr
    import pcie_pkg::*;
(
    input  wire logic                      pcie_clk,
    input  wire logic                      pcie_reset_n,
    // pio port
    input  wire pio_req_t                  pio_req,
    output logic [`PIO_DATA_WIDTH-1:0]     pio_readdata,
    output logic                           pio_readdatavalid,
    // dma completion
    input  wire logic                      dma_done_valid,
    input  wire logic [`TAIL_WIDTH-1:0]    dma_done_tail,
    output logic                           dma_done_ready,
    output active_queue_t                  active_queue,
    // status bus
    input  wire status_req_t               status_req,
    output logic [31:0]                    status_readdata,
    output logic                           status_readdata_valid,
    output logic                           disable_pcie
);

    queue_cfg_array_t               queue_cfgs;
    tail_array_t                    tails;
    logic [`QUEUE_IDX_WIDTH:0]      num_queues;
    logic                           tbl_wr_valid;
    tbl_wr_req_t                    tbl_wr_req;
    logic                           tbl_wr_ready;
    logic                           tbl_rd_valid;
    logic [`QUEUE_IDX_WIDTH-1:0]    tbl_rd_queue;
    logic                           tbl_rd_ready;
    logic [`TAIL_WIDTH-1:0]         tbl_rd_data;
    logic                           tbl_rd_rsp_valid;

    pio_reg_file pio_reg_file_inst (
        .pcie_clk          (pcie_clk),
        .pcie_reset_n      (pcie_reset_n),
        .pio_req           (pio_req),
        .tails             (tails),
        .pio_readdata      (pio_readdata),
        .pio_readdatavalid (pio_readdatavalid),
        .queue_cfgs        (queue_cfgs)
    );

    queue_scheduler queue_scheduler_inst (
        .pcie_clk       (pcie_clk),
        .pcie_reset_n   (pcie_reset_n),
        .dma_done_valid (dma_done_valid),
        .dma_done_tail  (dma_done_tail),
        .dma_done_ready (dma_done_ready),
        .num_queues     (num_queues),
        .queue_cfgs     (queue_cfgs),
        .tails          (tails),
        .active_queue   (active_queue),
        .tbl_wr_valid   (tbl_wr_valid),
        .tbl_wr_req     (tbl_wr_req),
        .tbl_wr_ready   (tbl_wr_ready)
    );

    // shared between scheduler writes and status reads
    queue_tail_table queue_tail_table_inst (
        .pcie_clk         (pcie_clk),
        .pcie_reset_n     (pcie_reset_n),
        .tbl_wr_valid     (tbl_wr_valid),
        .tbl_wr_req       (tbl_wr_req),
        .tbl_wr_ready     (tbl_wr_ready),
        .tbl_rd_valid     (tbl_rd_valid),
        .tbl_rd_queue     (tbl_rd_queue),
        .tbl_rd_ready     (tbl_rd_ready),
        .tbl_rd_data      (tbl_rd_data),
        .tbl_rd_rsp_valid (tbl_rd_rsp_valid)
    );

    status_bus_slave status_bus_slave_inst (
        .pcie_clk              (pcie_clk),
        .pcie_reset_n          (pcie_reset_n),
        .status_req            (status_req),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid),
        .num_queues            (num_queues),
        .disable_pcie          (disable_pcie),
        .tbl_rd_valid          (tbl_rd_valid),
        .tbl_rd_queue          (tbl_rd_queue),
        .tbl_rd_ready          (tbl_rd_ready),
        .tbl_rd_data           (tbl_rd_data),
        .tbl_rd_rsp_valid      (tbl_rd_rsp_valid)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic pcie_clk,
    output logic pcie_reset_n
);

    // 4 ns period
    initial begin
        pcie_clk = 1'b0;
        forever #2 pcie_clk = ~pcie_clk;
    end

    initial begin
        pcie_reset_n = 1'b0;
        repeat (10) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/pcie_queue_mgr_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module pcie_queue_mgr_tb
    import pcie_pkg::*;
();

    localparam int TIMEOUT = 200;

    typedef enum {OP_PIO_WR, OP_PIO_RD, OP_ST_WR, OP_ST_RD, OP_DMA, OP_DMA_ST_RD,
                  OP_DMA_BURST} op_t;
    typedef enum {W_RESET, W_READY, W_PIO, W_STATUS} wait_t;

    // queue is the pio page or the status address
    typedef struct {
        op_t         op;
        int          queue;
        logic [31:0] data;
        logic [15:0] be;
        logic [31:0] exp;
    } entry_t;

    logic                       pcie_clk;
    logic                       pcie_reset_n;
    pio_req_t                   pio_req;
    logic [`PIO_DATA_WIDTH-1:0] pio_readdata;
    logic                       pio_readdatavalid;
    logic                       dma_done_valid;
    logic [`TAIL_WIDTH-1:0]     dma_done_tail;
    logic                       dma_done_ready;
    active_queue_t              active_queue;
    status_req_t                status_req;
    logic [31:0]                status_readdata;
    logic                       status_readdata_valid;
    logic                       disable_pcie;

    entry_t      tests[$];
    logic [15:0] lfsr_state;
    int          errors;
    int          test_errors;
    int          failed_tests;

    // model of head, kmem low and kmem high per queue, scheduler tails and tail table
    logic [31:0] m_cfg[`MAX_QUEUES][3];
    logic [15:0] m_tail[`MAX_QUEUES];
    logic [15:0] m_tbl[`MAX_QUEUES];
    int          m_id;
    int          m_num;

    tb_clock_gen tb_clock_gen_inst (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n)
    );

    pcie_queue_mgr pcie_queue_mgr_inst (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [127:0] take_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // round robin that wraps at num_queues and stays on queue 0 for 0 or 1
    function automatic int next_queue(input int id, input int num);
        if (num <= 1 || id == num - 1) return 0;
        return (id + 1) % `MAX_QUEUES;
    endfunction

    function automatic logic [127:0] model_page(input int q);
        return {m_cfg[q][2], m_cfg[q][1], m_cfg[q][0], 16'h0, m_tail[q]};
    endfunction

    function automatic logic wait_hit(input wait_t w);
        case (w)
            W_RESET: return pcie_reset_n;
            W_READY: return dma_done_ready;
            W_PIO:   return pio_readdatavalid;
            default: return status_readdata_valid;
        endcase
    endfunction

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
            test_errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Finished with errors");
        $finish;
    endtask

    // counts falling edges until the signal is high
    task automatic wait_high(input wait_t w, output int cycles);
        cycles = 0;
        do begin
            @(negedge pcie_clk);
            cycles++;
        end while (!wait_hit(w) && cycles < TIMEOUT);
        if (!wait_hit(w)) stop_on_timeout(w.name());
    endtask

    task automatic pio_write(input int q, input logic [127:0] d, input logic [15:0] be);
        @(posedge pcie_clk);
        pio_req.address    <= 16'(q << `PAGE_LSB);
        pio_req.write      <= 1'b1;
        pio_req.writedata  <= d;
        pio_req.byteenable <= be;
        @(posedge pcie_clk);
        pio_req.write <= 1'b0;
        // dword 0 is the tail and never written
        for (int dw = 1; dw < 4; dw++) begin
            if (&be[4*dw +: 4]) m_cfg[q][dw-1] = d[32*dw +: 32];
        end
    endtask

    task automatic pio_read(input int q);
        int cycles;
        @(posedge pcie_clk);
        pio_req.address <= 16'(q << `PAGE_LSB);
        pio_req.read    <= 1'b1;
        @(posedge pcie_clk);
        pio_req.read <= 1'b0;
        wait_high(W_PIO, cycles);
        check_value(128'(cycles), 128'(2), "pio read latency");
        check_value(pio_readdata, model_page(q), $sformatf("pio page %0d", q));
    endtask

    task automatic status_write(input int addr, input logic [31:0] d);
        @(posedge pcie_clk);
        status_req.address   <= 8'(addr);
        status_req.write     <= 1'b1;
        status_req.writedata <= d;
        @(posedge pcie_clk);
        status_req.write <= 1'b0;
        // control register loads on the second edge
        @(posedge pcie_clk);
        if (addr == 0) m_num = int'(d[3:1]);
    endtask

    task automatic status_read(input int addr, output logic [31:0] data, output int cycles);
        @(posedge pcie_clk);
        status_req.address <= 8'(addr);
        status_req.read    <= 1'b1;
        @(posedge pcie_clk);
        status_req.read <= 1'b0;
        wait_high(W_STATUS, cycles);
        data = status_readdata;
    endtask

    task automatic accept_model(input logic [15:0] t);
        m_tail[m_id] = t;
        m_tbl[m_id]  = t;
        m_id         = next_queue(m_id, m_num);
    endtask

    task automatic dma_complete(input logic [15:0] t);
        int cycles;
        @(posedge pcie_clk);
        dma_done_valid <= 1'b1;
        dma_done_tail  <= t;
        wait_high(W_READY, cycles);
        // transfer on this edge
        @(posedge pcie_clk);
        dma_done_valid <= 1'b0;
        accept_model(t);
        wait_high(W_READY, cycles);
    endtask

    task automatic dma_burst(input int n_cycles);
        int   handshakes;
        int   falls;
        int   cycles;
        logic prev_ready;
        logic hs;
        handshakes = 0;
        falls      = 0;
        cycles     = 0;
        prev_ready = 1'b1;
        @(posedge pcie_clk);
        dma_done_valid <= 1'b1;
        dma_done_tail  <= 16'(take_bits(16));
        for (int i = 0; i < n_cycles; i++) begin
            @(negedge pcie_clk);
            if (prev_ready && !dma_done_ready) falls++;
            prev_ready = dma_done_ready;
            hs = dma_done_valid && dma_done_ready;
            if (hs) begin
                handshakes++;
                accept_model(dma_done_tail);
            end
            @(posedge pcie_clk);
            if (i == n_cycles - 1) begin
                dma_done_valid <= 1'b0;
            end else if (hs) begin
                dma_done_tail <= 16'(take_bits(16));
            end
        end
        // each acceptance drops ready once
        do begin
            @(negedge pcie_clk);
            if (prev_ready && !dma_done_ready) falls++;
            prev_ready = dma_done_ready;
            cycles++;
        end while (!dma_done_ready && cycles < TIMEOUT);
        if (!dma_done_ready) stop_on_timeout("dma_done_ready after burst");
        check_value(128'(handshakes > 0), 128'(1), "burst acceptances seen");
        check_value(128'(falls), 128'(handshakes), "acceptances vs handshake cycles");
    endtask

    task automatic check_active();
        active_queue_t exp;
        exp.queue_id  = 2'(m_id);
        exp.tail      = m_tail[m_id];
        exp.head      = m_cfg[m_id][0];
        exp.kmem_addr = {m_cfg[m_id][2], m_cfg[m_id][1]};
        check_value(128'(active_queue), 128'(exp), "active queue");
    endtask

    task automatic apply_entry(input entry_t e);
        logic [127:0] wdata;
        logic [15:0]  be;
        logic [31:0]  rdata;
        int           cycles;
        case (e.op)
            OP_PIO_WR: begin
                wdata = take_bits(128);
                be    = (e.be != 16'h0) ? e.be : 16'(take_bits(16));
                pio_write(e.queue, wdata, be);
            end
            OP_PIO_RD: pio_read(e.queue);
            OP_ST_WR: begin
                status_write(e.queue, e.data);
                @(negedge pcie_clk);
                check_value(128'(disable_pcie), 128'(e.exp[0]), "disable_pcie");
            end
            OP_ST_RD: begin
                status_read(e.queue, rdata, cycles);
                if (e.queue == 0) begin
                    check_value(128'(rdata), 128'(e.exp), "control register");
                    check_value(128'(cycles), 128'(2), "control read latency");
                end else begin
                    check_value(128'(rdata), 128'(m_tbl[e.queue-1]), "tail table entry");
                end
            end
            OP_DMA: begin
                dma_complete(16'(take_bits(16)));
                check_active();
            end
            OP_DMA_ST_RD: begin
                wdata = take_bits(16);
                // table read contends with the scheduler write
                fork
                    dma_complete(wdata[15:0]);
                    status_read(e.queue, rdata, cycles);
                join
                check_value(128'(rdata), 128'(m_tbl[e.queue-1]), "tail table entry");
                check_active();
            end
            OP_DMA_BURST: begin
                dma_burst(int'(e.data));
                check_active();
            end
        endcase
    endtask

    task automatic add_entry(input op_t op, input int queue, input logic [31:0] data,
                             input logic [15:0] be, input logic [31:0] exp);
        entry_t e;
        e.op    = op;
        e.queue = queue;
        e.data  = data;
        e.be    = be;
        e.exp   = exp;
        tests.push_back(e);
    endtask

    task automatic build_table();
        for (int q = 0; q < `MAX_QUEUES; q++) add_entry(OP_PIO_WR, q, 32'h0, 16'hFFFF, 32'h0);
        for (int q = 0; q < `MAX_QUEUES; q++) add_entry(OP_PIO_RD, q, 32'h0, 16'h0, 32'h0);
        // tail dword only, lfsr enables and a partial kmem low
        add_entry(OP_PIO_WR, 1, 32'h0, 16'h000F, 32'h0);
        add_entry(OP_PIO_RD, 1, 32'h0, 16'h0, 32'h0);
        add_entry(OP_PIO_WR, 2, 32'h0, 16'h0, 32'h0);
        add_entry(OP_PIO_RD, 2, 32'h0, 16'h0, 32'h0);
        add_entry(OP_PIO_WR, 3, 32'h0, 16'hF7F0, 32'h0);
        add_entry(OP_PIO_RD, 3, 32'h0, 16'h0, 32'h0);
        // three queues with the core disabled and then enabled
        add_entry(OP_ST_WR, 0, 32'h7, 16'h0, 32'h1);
        add_entry(OP_ST_RD, 0, 32'h0, 16'h0, 32'h7);
        add_entry(OP_ST_WR, 0, 32'h6, 16'h0, 32'h0);
        add_entry(OP_ST_RD, 0, 32'h0, 16'h0, 32'h6);
        add_entry(OP_ST_RD, 1, 32'h0, 16'h0, 32'h0);
        // queues 0, 1, 2, 0 with a page read of the finished one
        for (int k = 0; k < 4; k++) begin
            add_entry(OP_DMA, 0, 32'h0, 16'h0, 32'h0);
            add_entry(OP_PIO_RD, k % 3, 32'h0, 16'h0, 32'h0);
        end
        for (int q = 0; q < 3; q++) add_entry(OP_ST_RD, q + 1, 32'h0, 16'h0, 32'h0);
        // active queue is 1 here so these read entries of other queues
        add_entry(OP_DMA_ST_RD, 3, 32'h0, 16'h0, 32'h0);
        add_entry(OP_DMA_ST_RD, 1, 32'h0, 16'h0, 32'h0);
        add_entry(OP_DMA_BURST, 0, 32'd40, 16'h0, 32'h0);
        for (int q = 0; q < 3; q++) begin
            add_entry(OP_PIO_RD, q, 32'h0, 16'h0, 32'h0);
            add_entry(OP_ST_RD, q + 1, 32'h0, 16'h0, 32'h0);
        end
        add_entry(OP_ST_WR, 0, 32'h8, 16'h0, 32'h0);
        for (int k = 0; k < 4; k++) add_entry(OP_DMA, 0, 32'h0, 16'h0, 32'h0);
        add_entry(OP_PIO_RD, 3, 32'h0, 16'h0, 32'h0);
        add_entry(OP_ST_RD, 4, 32'h0, 16'h0, 32'h0);
    endtask

    task automatic report_test(input int idx, input string name);
        $display("test %0d %s: %s", idx, name, (test_errors == 0) ? "ok" : "failed");
        if (test_errors != 0) failed_tests++;
        errors += test_errors;
    endtask

    initial begin
        int cycles;
        pio_req        = '0;
        dma_done_valid = 1'b0;
        dma_done_tail  = '0;
        status_req     = '0;
        lfsr_state     = 16'd79;
        errors         = 0;
        failed_tests   = 0;
        m_id           = 0;
        m_num          = 0;
        for (int q = 0; q < `MAX_QUEUES; q++) begin
            m_tail[q] = '0;
            m_tbl[q]  = '0;
            m_cfg[q]  = '{default: '0};
        end
        build_table();

        wait_high(W_RESET, cycles);
        test_errors = 0;
        check_value(128'(pio_readdatavalid), 128'(0), "pio_readdatavalid after reset");
        check_value(128'(status_readdata_valid), 128'(0), "status valid after reset");
        check_value(128'(disable_pcie), 128'(0), "disable_pcie after reset");
        check_value(128'(dma_done_ready), 128'(1), "dma_done_ready after reset");
        check_value(128'(active_queue), 128'(0), "active queue after reset");
        report_test(0, "RESET");

        foreach (tests[i]) begin
            test_errors = 0;
            apply_entry(tests[i]);
            report_test(i + 1, tests[i].op.name());
        end

        $display("tests %0d, failed %0d, check errors %0d", tests.size() + 1, failed_tests,
                 errors);
        if (failed_tests == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pcie_queue_mgr.f
+incdir+include
logic/pcie_pkg.sv
logic/pio_reg_file.sv
logic/queue_scheduler.sv
logic/queue_tail_table.sv
logic/status_bus_slave.sv
logic/pcie_queue_mgr.sv
verification/tb_clock_gen.sv
verification/pcie_queue_mgr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f pcie_queue_mgr.f --top-module pcie_queue_mgr_tb --Mdir "$BUILD" -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
